// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l1_cache
SEED_LOG  ?= sim.log
FLAGS     ?= --binary --timing -Wno-fatal

BIN  := obj_dir/V$(TOP)
SRCS := $(filter-out +%,$(shell cat vlog.f))
HDRS := $(wildcard *.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(HDRS) vlog.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f vlog.f

run: $(BIN)
	./$(BIN) > $(SEED_LOG) 2>&1 || true
	cat $(SEED_LOG)

check: run
	grep -q "ALL TESTS PASSED" $(SEED_LOG)

clean:
	rm -rf obj_dir $(SEED_LOG)

// File: cache_defs.svh
/*
 * geometry macros for the 2-way L1 data cache
 * derived field widths for address split
 */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

`define CACHE_WORD_W      32    // data word, bits
`define CACHE_SETS        8
`define CACHE_WAYS        2     // fixed, LRU is one bit per set
`define CACHE_BLOCK_WORDS 2     // words per frame

// address fields, byte offset is always 2 bits
`define CACHE_SET_BITS    $clog2(`CACHE_SETS)
`define CACHE_BLOCK_BITS  $clog2(`CACHE_BLOCK_WORDS)
`define CACHE_TAG_BITS    (`CACHE_WORD_W - `CACHE_SET_BITS - `CACHE_BLOCK_BITS - 2)

`endif

// File: cache_frame_store.sv
/*
 * frame store: data, tag, valid, dirty per frame
 * one LRU bit per set, single write port, async read of one set
 */
`include "cache_defs.svh"

module cache_frame_store (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::set_idx_t rd_set,
    // write port, one frame per cycle
    input  logic                wr_en,
    input  cache_pkg::set_idx_t wr_set,
    input  cache_pkg::way_t     wr_way,
    input  cache_pkg::blk_idx_t wr_word,
    input  cache_pkg::word_t    wr_data,
    input  logic                wr_data_en,
    input  cache_pkg::tag_t     wr_tag,
    input  logic                wr_tag_en,
    input  logic                wr_dirty,
    input  logic                lru_en,
    input  cache_pkg::way_t     lru_way,
    // indexed set
    output cache_pkg::tag_t [`CACHE_WAYS-1:0]                         set_tags,
    output logic [`CACHE_WAYS-1:0]                                    set_valid,
    output logic [`CACHE_WAYS-1:0]                                    set_dirty,
    output cache_pkg::word_t [`CACHE_WAYS-1:0][`CACHE_BLOCK_WORDS-1:0] set_data,
    output cache_pkg::way_t                                           set_lru
);
    cache_pkg::word_t       data_q  [`CACHE_SETS][`CACHE_WAYS][`CACHE_BLOCK_WORDS];
    cache_pkg::tag_t        tag_q   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    cache_pkg::way_t        lru_q   [`CACHE_SETS];   // most recently used way

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    tag_q[s][w] <= '0;
                    for (int b = 0; b < `CACHE_BLOCK_WORDS; b++) begin
                        data_q[s][w][b] <= '0;
                    end
                end
            end
        end else begin
            if (wr_en) begin
                dirty_q[wr_set][wr_way] <= wr_dirty;   // every write sets the dirty state
                if (wr_data_en) begin
                    data_q[wr_set][wr_way][wr_word] <= wr_data;
                end
                if (wr_tag_en) begin   // last refill word
                    tag_q[wr_set][wr_way]   <= wr_tag;
                    valid_q[wr_set][wr_way] <= 1'b1;
                end
            end
            if (lru_en) begin
                lru_q[wr_set] <= lru_way;
            end
        end
    end

    // read side, purely combinational
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            set_tags[w] = tag_q[rd_set][w];
            for (int b = 0; b < `CACHE_BLOCK_WORDS; b++) begin
                set_data[w][b] = data_q[rd_set][w][b];
            end
        end
    end

    assign set_valid = valid_q[rd_set];
    assign set_dirty = dirty_q[rd_set];
    assign set_lru   = lru_q[rd_set];

endmodule

// File: cache_lookup.sv
/*
 * tag compare across both ways, hit word select
 * byte-enable merge for write hits, LRU victim pick
 */
`include "cache_defs.svh"

module cache_lookup (
    input  cache_pkg::word_t    proc_addr,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    input  cache_pkg::tag_t [`CACHE_WAYS-1:0]                         set_tags,
    input  logic [`CACHE_WAYS-1:0]                                    set_valid,
    input  logic [`CACHE_WAYS-1:0]                                    set_dirty,
    input  cache_pkg::word_t [`CACHE_WAYS-1:0][`CACHE_BLOCK_WORDS-1:0] set_data,
    input  cache_pkg::way_t     set_lru,
    output cache_pkg::decoded_addr_t addr_f,
    output logic                hit,
    output cache_pkg::way_t     hit_way,
    output cache_pkg::word_t    hit_word,
    output cache_pkg::word_t    merged_word,
    output cache_pkg::way_t     victim_way,
    output logic                victim_dirty,
    output cache_pkg::tag_t     victim_tag
);
    assign addr_f = proc_addr;   // plain field split

    // at most one way matches, tags in a set are distinct
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (set_valid[w] && set_tags[w] == addr_f.tag) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit_word = set_data[hit_way][addr_f.blk];

    // enabled lanes from the write data, others kept
    always_comb begin
        for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
            merged_word[8*b +: 8] = proc_byte_en[b] ? proc_wdata[8*b +: 8]
                                                    : hit_word[8*b +: 8];
        end
    end

    // two ways, so the victim is simply the other one
    assign victim_way   = ~set_lru;
    assign victim_dirty = set_dirty[victim_way];
    assign victim_tag   = set_tags[victim_way];

endmodule

// File: cache_miss_ctrl.sv
/*
 * miss controller FSM: idle/hit handling, write-back, refill, flush
 * word, way and set counters, memory bus drive, frame store writes
 */
`include "cache_defs.svh"

module cache_miss_ctrl (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  cache_pkg::decoded_addr_t addr_f,
    input  logic                     hit,
    input  cache_pkg::way_t          hit_way,
    input  cache_pkg::word_t         hit_word,
    input  cache_pkg::word_t         merged_word,
    input  cache_pkg::way_t          victim_way,
    input  logic                     victim_dirty,
    input  cache_pkg::tag_t          victim_tag,
    input  cache_pkg::tag_t [`CACHE_WAYS-1:0]                         set_tags,
    input  logic [`CACHE_WAYS-1:0]                                    set_dirty,
    input  cache_pkg::word_t [`CACHE_WAYS-1:0][`CACHE_BLOCK_WORDS-1:0] set_data,
    input  logic                     flush,
    input  cache_pkg::word_t         mem_rdata,
    input  logic                     mem_busy,
    output cache_pkg::word_t         proc_rdata,
    output logic                     proc_busy,
    output logic                     flush_done,
    output cache_pkg::word_t         mem_addr,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output cache_pkg::word_t         mem_wdata,
    // frame store controls
    output cache_pkg::set_idx_t      rd_set,
    output logic                     wr_en,
    output cache_pkg::set_idx_t      wr_set,
    output cache_pkg::way_t          wr_way,
    output cache_pkg::blk_idx_t      wr_word,
    output cache_pkg::word_t         wr_data,
    output logic                     wr_data_en,
    output cache_pkg::tag_t          wr_tag,
    output logic                     wr_tag_en,
    output logic                     wr_dirty,
    output logic                     lru_en,
    output cache_pkg::way_t          lru_way
);
    cache_pkg::ctrl_state_t state, next_state;
    cache_pkg::blk_idx_t    word_cnt;    // word within block on the memory bus
    cache_pkg::set_idx_t    flush_set;
    cache_pkg::way_t        flush_way;
    logic                   word_adv, flush_adv;
    logic                   last_word, last_frame, flushing;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= cache_pkg::IDLE;
            word_cnt  <= '0;
            flush_set <= '0;
            flush_way <= '0;
        end else begin
            state <= next_state;
            if (word_adv) begin
                word_cnt <= word_cnt + 1'b1;   // wraps to 0 after the last word
            end
            if (flush_adv) begin
                {flush_set, flush_way} <= {flush_set, flush_way} + 1'b1;   // way is the low digit
            end
        end
    end

    assign last_word  = word_cnt == cache_pkg::blk_idx_t'(`CACHE_BLOCK_WORDS - 1);
    assign last_frame = flush_set == cache_pkg::set_idx_t'(`CACHE_SETS - 1)
                     && flush_way == cache_pkg::way_t'(`CACHE_WAYS - 1);
    assign flushing   = state == cache_pkg::FLUSH_SCAN || state == cache_pkg::FLUSH_WB;

    // flush walks its own set, otherwise the request's set
    assign rd_set     = flushing ? flush_set : addr_f.idx;
    assign wr_set     = rd_set;
    assign wr_tag     = addr_f.tag;   // only written at refill end
    assign proc_rdata = hit_word;     // qualified by proc_busy

    always_comb begin
        next_state = state;
        proc_busy  = 1'b1;
        flush_done = 1'b0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        word_adv   = 1'b0;
        flush_adv  = 1'b0;
        wr_en      = 1'b0;
        wr_way     = victim_way;
        wr_word    = word_cnt;
        wr_data    = mem_rdata;
        wr_data_en = 1'b0;
        wr_tag_en  = 1'b0;
        wr_dirty   = 1'b0;
        lru_en     = 1'b0;
        lru_way    = hit_way;

        case (state)
            cache_pkg::IDLE: begin
                if (proc_ren || proc_wen) begin
                    if (hit) begin   // completes this cycle
                        proc_busy = 1'b0;
                        lru_en    = 1'b1;
                        if (proc_wen) begin
                            wr_en      = 1'b1;
                            wr_way     = hit_way;
                            wr_word    = addr_f.blk;
                            wr_data    = merged_word;
                            wr_data_en = 1'b1;
                            wr_dirty   = 1'b1;
                        end
                    end else if (victim_dirty) begin
                        next_state = cache_pkg::WB;
                    end else begin
                        next_state = cache_pkg::FETCH;
                    end
                end else if (flush) begin
                    next_state = cache_pkg::FLUSH_SCAN;
                end
            end

            cache_pkg::WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, addr_f.idx, word_cnt, 2'b00};
                mem_wdata = set_data[victim_way][word_cnt];
                if (!mem_busy) begin
                    word_adv = 1'b1;
                    if (last_word) begin
                        wr_en      = 1'b1;   // victim now clean
                        next_state = cache_pkg::FETCH;
                    end
                end
            end

            cache_pkg::FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {addr_f.tag, addr_f.idx, word_cnt, 2'b00};
                if (!mem_busy) begin
                    word_adv   = 1'b1;
                    wr_en      = 1'b1;
                    wr_data_en = 1'b1;
                    if (last_word) begin
                        wr_tag_en  = 1'b1;   // tag and valid with the final word
                        next_state = cache_pkg::IDLE;
                    end
                end
            end

            // one cycle per frame, a dirty frame detours through FLUSH_WB
            cache_pkg::FLUSH_SCAN: begin
                if (set_dirty[flush_way]) begin
                    next_state = cache_pkg::FLUSH_WB;
                end else begin
                    flush_adv = 1'b1;
                    if (last_frame) begin
                        flush_done = 1'b1;
                        next_state = cache_pkg::IDLE;
                    end
                end
            end

            cache_pkg::FLUSH_WB: begin
                mem_wen   = 1'b1;
                mem_addr  = {set_tags[flush_way], flush_set, word_cnt, 2'b00};
                mem_wdata = set_data[flush_way][word_cnt];
                wr_way    = flush_way;
                if (!mem_busy) begin
                    word_adv = 1'b1;
                    if (last_word) begin
                        wr_en      = 1'b1;   // clear dirty, rescan same frame
                        next_state = cache_pkg::FLUSH_SCAN;
                    end
                end
            end

            default: next_state = cache_pkg::IDLE;
        endcase
    end

endmodule

// File: cache_pkg.sv
/*
 * shared types for the L1 data cache
 * word, byte enable, address fields, decoded address, controller states
 */
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0]          word_t;
    typedef logic [`CACHE_WORD_W/8-1:0]        byte_en_t;   // one bit per byte lane
    typedef logic [`CACHE_TAG_BITS-1:0]        tag_t;
    typedef logic [`CACHE_SET_BITS-1:0]        set_idx_t;
    typedef logic [`CACHE_BLOCK_BITS-1:0]      blk_idx_t;   // word within block
    typedef logic [$clog2(`CACHE_WAYS)-1:0]    way_t;

    // word address split, msb first
    typedef struct packed {
        tag_t       tag;
        set_idx_t   idx;
        blk_idx_t   blk;
        logic [1:0] byte_off;   // ignored, word accesses only
    } decoded_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        WB,          // victim write-back
        FETCH,       // block refill
        FLUSH_SCAN,  // walk sets and ways looking for dirty frames
        FLUSH_WB     // write one dirty frame out
    } ctrl_state_t;

endpackage

// File: l1_cache.sv
/*
 * write-back L1 data cache, 2-way, 8 sets of 2-word blocks
 * lookup, frame store and miss controller wired to processor and memory
 */
`include "cache_defs.svh"

module l1_cache (
    input  logic                CLK,
    input  logic                nRST,
    // processor side
    input  cache_pkg::word_t    proc_addr,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    output cache_pkg::word_t    proc_rdata,
    output logic                proc_busy,
    input  logic                flush,
    output logic                flush_done,
    // memory side
    output cache_pkg::word_t    mem_addr,
    output logic                mem_ren,
    output logic                mem_wen,
    output cache_pkg::word_t    mem_wdata,
    input  cache_pkg::word_t    mem_rdata,
    input  logic                mem_busy
);
    // contents of the indexed set
    cache_pkg::tag_t [`CACHE_WAYS-1:0]                         set_tags;
    logic [`CACHE_WAYS-1:0]                                    set_valid;
    logic [`CACHE_WAYS-1:0]                                    set_dirty;
    cache_pkg::word_t [`CACHE_WAYS-1:0][`CACHE_BLOCK_WORDS-1:0] set_data;
    cache_pkg::way_t                                           set_lru;

    // lookup results
    cache_pkg::decoded_addr_t addr_f;
    logic                     hit;
    cache_pkg::way_t          hit_way;
    cache_pkg::word_t         hit_word;
    cache_pkg::word_t         merged_word;
    cache_pkg::way_t          victim_way;
    logic                     victim_dirty;
    cache_pkg::tag_t          victim_tag;

    // frame store controls from the controller
    cache_pkg::set_idx_t rd_set;
    cache_pkg::set_idx_t wr_set;
    cache_pkg::way_t     wr_way;
    cache_pkg::blk_idx_t wr_word;
    cache_pkg::word_t    wr_data;
    cache_pkg::tag_t     wr_tag;
    cache_pkg::way_t     lru_way;
    logic                wr_en, wr_data_en, wr_tag_en, wr_dirty, lru_en;

    cache_lookup i_lookup (
        .proc_addr, .proc_wdata, .proc_byte_en,
        .set_tags, .set_valid, .set_dirty, .set_data, .set_lru,
        .addr_f, .hit, .hit_way, .hit_word, .merged_word,
        .victim_way, .victim_dirty, .victim_tag
    );

    cache_frame_store i_frame_store (
        .CLK, .nRST, .rd_set,
        .wr_en, .wr_set, .wr_way, .wr_word, .wr_data, .wr_data_en,
        .wr_tag, .wr_tag_en, .wr_dirty, .lru_en, .lru_way,
        .set_tags, .set_valid, .set_dirty, .set_data, .set_lru
    );

    cache_miss_ctrl i_miss_ctrl (
        .CLK, .nRST, .proc_ren, .proc_wen,
        .addr_f, .hit, .hit_way, .hit_word, .merged_word,
        .victim_way, .victim_dirty, .victim_tag,
        .set_tags, .set_dirty, .set_data,
        .flush, .mem_rdata, .mem_busy,
        .proc_rdata, .proc_busy, .flush_done,
        .mem_addr, .mem_ren, .mem_wen, .mem_wdata,
        .rd_set, .wr_en, .wr_set, .wr_way, .wr_word, .wr_data, .wr_data_en,
        .wr_tag, .wr_tag_en, .wr_dirty, .lru_en, .lru_way
    );

endmodule

// File: tb_l1_cache.sv
/*
 * testbench for the L1 data cache: clock, reset, random stimulus
 * flat word model, per-test report, watchdog
 */
`include "cache_defs.svh"

module tb_l1_cache;
    localparam int          HALF       = 5;    // clock half period
    localparam int          SAMPLE_DLY = 4;    // after the falling edge, before the rising one
    localparam int          MEM_WORDS  = 64;
    localparam logic [31:0] FILL       = 32'h9E37_79B9;
    localparam int          N_FRESH    = 16;
    localparam int          N_MERGE    = 16;
    localparam int          N_RANDOM   = 300;
    localparam int          N_REQ      = 2 * N_FRESH + 2 * N_MERGE + N_RANDOM + 2;   // flushes too
    localparam int          LIMIT      = 200 * N_REQ + 2000;

    logic CLK, nRST;
    cache_pkg::word_t    proc_addr, proc_wdata, proc_rdata;
    cache_pkg::byte_en_t proc_byte_en;
    logic                proc_ren, proc_wen, proc_busy, flush, flush_done;
    cache_pkg::word_t    mem_addr, mem_wdata, mem_rdata;
    logic                mem_ren, mem_wen, mem_busy;

    cache_pkg::word_t model [MEM_WORDS];   // expected memory image
    integer seed;
    int     checks, errors, tests, test_checks, test_errors;

    l1_cache i_l1_cache (.*);

    tb_mem #(.DEPTH(MEM_WORDS), .FILL(FILL), .SEED(41103)) i_mem (
        .CLK, .mem_addr, .mem_ren, .mem_wen, .mem_wdata, .mem_rdata, .mem_busy
    );

    initial begin
        CLK = 1'b0;
        forever #HALF CLK = ~CLK;
    end

    // 32 words over sets 0..3 with 4 tags each, so ways get evicted
    function automatic cache_pkg::word_t word_addr(input logic [4:0] sel);
        return {24'h0, sel[4:3], 1'b0, sel[2:1], sel[0], 2'b00};
    endfunction

    function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
                                                     input cache_pkg::word_t new_w,
                                                     input cache_pkg::byte_en_t be);
        cache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];   // enabled lane replaced
        end
        return res;
    endfunction

    task automatic check_eq(input string sig, input cache_pkg::word_t addr,
                            input cache_pkg::word_t got, input cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s addr=%h got=%h exp=%h", sig, addr, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // one blocking request, called on a falling edge, returns on a falling edge
    task automatic access(input logic is_wr, input cache_pkg::word_t addr,
                          input cache_pkg::word_t wd, input cache_pkg::byte_en_t be,
                          output cache_pkg::word_t rd);
        logic done;
        done         = 1'b0;
        proc_addr    = addr;
        proc_ren     = !is_wr;
        proc_wen     = is_wr;
        proc_wdata   = wd;
        proc_byte_en = be;
        while (!done) begin
            #SAMPLE_DLY;
            if (!proc_busy) begin   // completes at the coming rising edge
                rd   = proc_rdata;
                done = 1'b1;
            end
            @(negedge CLK);
        end
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    // hold flush until the done pulse, count cycles with a memory write
    task automatic flush_run(output int wen_cycles);
        logic done;
        done       = 1'b0;
        wen_cycles = 0;
        flush      = 1'b1;
        while (!done) begin
            #SAMPLE_DLY;
            if (mem_wen) wen_cycles++;
            if (flush_done) done = 1'b1;
            @(negedge CLK);
        end
        flush = 1'b0;
    endtask

    initial begin : watchdog
        repeat (LIMIT) @(posedge CLK);
        $display("watchdog: run did not finish within %0d cycles", LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        cache_pkg::word_t    a, wd, rd, rd2;
        cache_pkg::byte_en_t be;
        logic [31:0]         r;
        int                  wc;
        seed = 41103;
        {checks, errors, tests, test_checks, test_errors} = '0;
        nRST = 1'b0;
        {proc_addr, proc_wdata, proc_byte_en} = '0;
        {proc_ren, proc_wen, flush} = '0;
        for (int i = 0; i < MEM_WORDS; i++) model[i] = i * FILL;   // same fill as memory
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        #SAMPLE_DLY;   // idle outputs after reset
        check_eq("mem_ren", 0, {31'h0, mem_ren}, 0);
        check_eq("mem_wen", 0, {31'h0, mem_wen}, 0);
        check_eq("flush_done", 0, {31'h0, flush_done}, 0);
        check_eq("proc_busy", 0, {31'h0, proc_busy}, 1);
        @(negedge CLK);
        end_test("reset state");

        for (int i = 0; i < N_FRESH; i++) begin
            r = $random(seed);
            a = word_addr(r[4:0]);
            access(1'b0, a, 0, 0, rd);    // miss and refill
            access(1'b0, a, 0, 0, rd2);   // now a hit
            check_eq("proc_rdata", a, rd, model[a[7:2]]);
            check_eq("proc_rdata", a, rd2, model[a[7:2]]);
        end
        end_test("refill reads");

        for (int i = 0; i < N_MERGE; i++) begin
            r  = $random(seed);
            a  = word_addr(r[4:0]);
            wd = $random(seed);
            be = r[11:8];
            access(1'b1, a, wd, be, rd);
            model[a[7:2]] = merge_bytes(model[a[7:2]], wd, be);
            access(1'b0, a, 0, 0, rd);
            check_eq("proc_rdata", a, rd, model[a[7:2]]);
        end
        end_test("byte-enable writes");

        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            a = word_addr(r[4:0]);
            if (r[8]) begin
                wd = $random(seed);
                access(1'b1, a, wd, r[15:12], rd);
                model[a[7:2]] = merge_bytes(model[a[7:2]], wd, r[15:12]);
            end else begin
                access(1'b0, a, 0, 0, rd);
                check_eq("proc_rdata", a, rd, model[a[7:2]]);
            end
        end
        end_test("random traffic");

        flush_run(wc);
        for (int k = 0; k < MEM_WORDS; k++) begin   // memory now matches the model
            check_eq("mem", k * 4, i_mem.mem[k], model[k]);
        end
        flush_run(wc);   // nothing dirty is left
        check_eq("mem_wen cycles", 0, wc, 0);
        end_test("flush");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb_mem.sv
/*
 * memory model for the cache's memory bus
 * word array with a fill pattern, random busy per cycle
 */
`include "cache_defs.svh"

module tb_mem #(
    parameter int          DEPTH = 64,
    parameter logic [31:0] FILL  = 32'h9E37_79B9,   // word i holds i * FILL
    parameter int          SEED  = 41103
) (
    input  logic             CLK,
    input  cache_pkg::word_t mem_addr,
    input  logic             mem_ren,
    input  logic             mem_wen,
    input  cache_pkg::word_t mem_wdata,
    output cache_pkg::word_t mem_rdata,
    output logic             mem_busy
);
    localparam int AW = $clog2(DEPTH);

    cache_pkg::word_t mem [DEPTH];
    logic [AW-1:0]    widx;        // word index from the byte address
    logic [31:0]      busy_rnd;
    integer           seed;

    initial begin
        seed = SEED;
        mem_busy <= 1'b1;   // busy until the first draw
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= i * FILL;
        end
    end

    assign widx      = mem_addr[AW+1:2];
    // stored word only while mem_ren is up, inverted otherwise
    assign mem_rdata = mem_ren ? mem[widx] : ~mem[widx];

    // new busy draw each falling edge, about half the cycles stall
    always @(negedge CLK) begin
        busy_rnd = $random(seed);
        mem_busy <= busy_rnd[0];
    end

    // a write transfers in the cycle busy is low
    always @(posedge CLK) begin
        if (mem_wen && !mem_busy) begin
            mem[widx] <= mem_wdata;
        end
    end

endmodule

// File: vlog.f
+incdir+.
cache_pkg.sv
cache_lookup.sv
cache_frame_store.sv
cache_miss_ctrl.sv
l1_cache.sv
tb_mem.sv
tb_l1_cache.sv
